//--- files.f
src/rv_pkg.sv
src/control_unit.sv
src/alu.sv
src/reg_file.sv
src/load_store_unit.sv
src/riscv_core.sv
testbench/tb_clock.sv
testbench/tb_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_core -f files.f \
    --Mdir obj_dir -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_core_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- src/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import rv_pkg::*; (
    input  alu_op_e     op,
    input  logic        word_op,
    input  logic [63:0] a,
    input  logic [63:0] b,
    output logic [63:0] result
);

    logic [63:0] full;
    logic [5:0]  shamt;

    assign shamt = b[5:0];

    always_comb begin
        unique case (op)
            ALU_ADD:    full = a + b;
            ALU_SUB:    full = a - b;
            ALU_SLT:    full = {63'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   full = {63'b0, a < b};
            ALU_AND:    full = a & b;
            ALU_OR:     full = a | b;
            ALU_XOR:    full = a ^ b;
            ALU_SLL:    full = a << shamt;
            ALU_SRL:    full = a >> shamt;
            ALU_SRA:    full = $unsigned($signed(a) >>> shamt);
            ALU_PASS_B: full = b;
            default:    full = a + b;
        endcase
    end

    // addw and addiw keep the low word, sign extended
    assign result = word_op ? {{32{full[31]}}, full[31:0]} : full;

endmodule

`default_nettype wire

//--- src/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit import rv_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output alu_op_e    alu_op,
    output logic       word_op,
    output logic       rf_we,
    output src1_sel_e  src1_sel,
    output src2_sel_e  src2_sel,
    output next_pc_e   next_pc,
    output rf_src_e    rf_src,
    output logic       mem_read,
    output logic       mem_write,
    output mem_size_e  mem_size,
    output logic       load_unsigned,
    output logic       illegal,
    output logic       halt
);

    logic f7_zero;
    logic f7_alt;
    logic is_op;

    logic inst_addi, inst_sltiu, inst_andi, inst_addiw;
    logic inst_lui, inst_auipc, inst_jal, inst_jalr;
    logic inst_add, inst_sub, inst_and, inst_or, inst_xor;
    logic inst_slt, inst_sltu, inst_sll, inst_srl, inst_sra, inst_addw;
    logic inst_branch, inst_load, inst_store, inst_ebreak;
    logic r_type;
    logic imm_type;

    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);
    assign is_op   = (opcode == OPC_OP);

    assign inst_addi  = (opcode == OPC_OP_IMM) && (funct3 == 3'b000);
    assign inst_sltiu = (opcode == OPC_OP_IMM) && (funct3 == 3'b011);
    assign inst_andi  = (opcode == OPC_OP_IMM) && (funct3 == 3'b111);
    assign inst_addiw = (opcode == OPC_OP_IMM_32) && (funct3 == 3'b000);
    assign inst_lui   = (opcode == OPC_LUI);
    assign inst_auipc = (opcode == OPC_AUIPC);
    assign inst_jal   = (opcode == OPC_JAL);
    assign inst_jalr  = (opcode == OPC_JALR) && (funct3 == 3'b000);

    assign inst_add  = is_op && (funct3 == 3'b000) && f7_zero;
    assign inst_sub  = is_op && (funct3 == 3'b000) && f7_alt;
    assign inst_sll  = is_op && (funct3 == 3'b001) && f7_zero;
    assign inst_slt  = is_op && (funct3 == 3'b010) && f7_zero;
    assign inst_sltu = is_op && (funct3 == 3'b011) && f7_zero;
    assign inst_xor  = is_op && (funct3 == 3'b100) && f7_zero;
    assign inst_srl  = is_op && (funct3 == 3'b101) && f7_zero;
    assign inst_sra  = is_op && (funct3 == 3'b101) && f7_alt;
    assign inst_or   = is_op && (funct3 == 3'b110) && f7_zero;
    assign inst_and  = is_op && (funct3 == 3'b111) && f7_zero;
    assign inst_addw = (opcode == OPC_OP_32) && (funct3 == 3'b000) && f7_zero;

    // beq bne blt bge bltu bgeu, 010 and 011 are reserved
    assign inst_branch = (opcode == OPC_BRANCH) && (funct3[2:1] != 2'b01);
    // lb lh lw ld lbu lhu lwu
    assign inst_load   = (opcode == OPC_LOAD) && (funct3 != 3'b111);
    assign inst_store  = (opcode == OPC_STORE) && !funct3[2];
    // ecall decodes the same way, rs2 is not visible here
    assign inst_ebreak = (opcode == OPC_SYSTEM) && (funct3 == 3'b000) && f7_zero;

    assign r_type = inst_add | inst_sub | inst_and | inst_or | inst_xor | inst_slt
                  | inst_sltu | inst_sll | inst_srl | inst_sra | inst_addw;
    assign imm_type = inst_addi | inst_sltiu | inst_andi | inst_addiw;

    always_comb begin
        alu_op = ALU_ADD; // also address and link arithmetic
        if (inst_sub || (inst_branch && funct3[2:1] == 2'b00)) begin
            alu_op = ALU_SUB;
        end else if (inst_slt || (inst_branch && funct3[2:1] == 2'b10)) begin
            alu_op = ALU_SLT;
        end else if (inst_sltu || inst_sltiu || (inst_branch && funct3[2:1] == 2'b11)) begin
            alu_op = ALU_SLTU;
        end else if (inst_and || inst_andi) begin
            alu_op = ALU_AND;
        end else if (inst_or) begin
            alu_op = ALU_OR;
        end else if (inst_xor) begin
            alu_op = ALU_XOR;
        end else if (inst_sll) begin
            alu_op = ALU_SLL;
        end else if (inst_srl) begin
            alu_op = ALU_SRL;
        end else if (inst_sra) begin
            alu_op = ALU_SRA;
        end else if (inst_lui) begin
            alu_op = ALU_PASS_B;
        end
    end

    always_comb begin
        src2_sel = SRC2_RS2;
        if (imm_type || inst_load)   src2_sel = SRC2_IMM_I;
        else if (inst_store)         src2_sel = SRC2_IMM_S;
        else if (inst_lui || inst_auipc) src2_sel = SRC2_IMM_U;
        else if (inst_jal || inst_jalr)  src2_sel = SRC2_FOUR;
    end

    assign src1_sel = (inst_auipc | inst_jal | inst_jalr) ? SRC1_PC : SRC1_RS1;

    assign next_pc = inst_jal    ? NPC_JAL :
                     inst_jalr   ? NPC_JALR :
                     inst_branch ? NPC_BRANCH : NPC_SEQ;

    assign word_op = inst_addw | inst_addiw;
    assign rf_we   = r_type | imm_type | inst_lui | inst_auipc | inst_jal | inst_jalr | inst_load;
    assign rf_src  = inst_load ? RF_LOAD : RF_ALU;

    assign mem_read      = inst_load;
    assign mem_write     = inst_store;
    assign mem_size      = mem_size_e'(funct3[1:0]);
    assign load_unsigned = inst_load & funct3[2];

    assign halt    = inst_ebreak;
    assign illegal = ~(r_type | imm_type | inst_lui | inst_auipc | inst_jal | inst_jalr
                     | inst_branch | inst_load | inst_store | inst_ebreak);

endmodule

`default_nettype wire

//--- src/load_store_unit.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_unit import rv_pkg::*; #(
    parameter int ADDR_W = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req,
    input  logic [ADDR_W-1:0] addr,
    input  logic              write,
    input  mem_size_e         size,
    input  logic              load_unsigned,
    input  logic [63:0]       store_data,
    input  logic [63:0]       wb_dat_r,
    input  logic              wb_ack,
    output logic              done,
    output logic [63:0]       read_data,
    output logic [ADDR_W-1:0] wb_adr,
    output logic [63:0]       wb_dat_w,
    output logic [7:0]        wb_sel,
    output logic              wb_we,
    output logic              wb_cyc,
    output logic              wb_stb
);

    logic [7:0]  base_mask;
    logic [2:0]  off_q;
    mem_size_e   size_q;
    logic        unsigned_q;
    logic [63:0] shifted;

    always_comb begin
        unique case (size)
            SIZE_B:  base_mask = 8'h01;
            SIZE_H:  base_mask = 8'h03;
            SIZE_W:  base_mask = 8'h0f;
            default: base_mask = 8'hff;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
        end else if (req) begin
            wb_cyc <= 1'b1;
            wb_we  <= write;
        end else if (done) begin // drop on the ack edge
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_adr     <= {addr[ADDR_W-1:3], 3'b000};
            wb_dat_w   <= store_data << {addr[2:0], 3'b000};
            wb_sel     <= base_mask << addr[2:0];
            off_q      <= addr[2:0];
            size_q     <= size;
            unsigned_q <= load_unsigned;
        end
    end

    assign wb_stb = wb_cyc;
    assign done   = wb_cyc & wb_ack;

    // bring the addressed lane down to bit 0
    assign shifted = wb_dat_r >> {off_q, 3'b000};

    always_comb begin
        unique case (size_q)
            SIZE_B:  read_data = {{56{~unsigned_q & shifted[7]}}, shifted[7:0]};
            SIZE_H:  read_data = {{48{~unsigned_q & shifted[15]}}, shifted[15:0]};
            SIZE_W:  read_data = {{32{~unsigned_q & shifted[31]}}, shifted[31:0]};
            default: read_data = shifted;
        endcase
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rd_addr,
    input  logic [63:0] rd_data,
    input  logic        we,
    output logic [63:0] rs1_data,
    output logic [63:0] rs2_data
);

    logic [63:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin // x0 never written
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

//--- src/riscv_core.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_core import rv_pkg::*; #(
    parameter logic [63:0] RESET_PC = 64'h0,
    parameter int          ADDR_W   = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [63:0]       wb_dat_r,
    input  logic              wb_ack,
    output logic [ADDR_W-1:0] wb_adr,
    output logic [63:0]       wb_dat_w,
    output logic [7:0]        wb_sel,
    output logic              wb_we,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              halted,
    output logic              illegal
);

    seq_state_e  state;
    logic [63:0] pc;
    logic [63:0] npc;
    logic [31:0] ir;

    alu_op_e   cu_alu_op;
    logic      cu_word_op, cu_rf_we, cu_mem_read, cu_mem_write;
    logic      cu_load_unsigned, cu_illegal, cu_halt;
    src1_sel_e cu_src1_sel;
    src2_sel_e cu_src2_sel;
    next_pc_e  cu_next_pc;
    rf_src_e   cu_rf_src;
    mem_size_e cu_mem_size;

    logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [63:0] rs1_data, rs2_data, alu_a, alu_b, alu_result;
    logic [63:0] lsu_read_data;
    logic        lsu_req, lsu_done, fetching, taken, stop, mem_access, rf_we;

    assign imm_i = {{52{ir[31]}}, ir[31:20]};
    assign imm_s = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {{32{ir[31]}}, ir[31:12], 12'b0};
    assign imm_j = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    control_unit u_control_unit (
        .opcode(ir[6:0]), .funct3(ir[14:12]), .funct7(ir[31:25]),
        .alu_op(cu_alu_op), .word_op(cu_word_op), .rf_we(cu_rf_we),
        .src1_sel(cu_src1_sel), .src2_sel(cu_src2_sel), .next_pc(cu_next_pc),
        .rf_src(cu_rf_src), .mem_read(cu_mem_read), .mem_write(cu_mem_write),
        .mem_size(cu_mem_size), .load_unsigned(cu_load_unsigned),
        .illegal(cu_illegal), .halt(cu_halt)
    );

    assign alu_a = (cu_src1_sel == SRC1_PC) ? pc : rs1_data;

    always_comb begin
        unique case (cu_src2_sel)
            SRC2_IMM_I: alu_b = imm_i;
            SRC2_IMM_S: alu_b = imm_s;
            SRC2_IMM_U: alu_b = imm_u;
            SRC2_FOUR:  alu_b = 64'd4;
            default:    alu_b = rs2_data;
        endcase
    end

    alu u_alu (.op(cu_alu_op), .word_op(cu_word_op), .a(alu_a), .b(alu_b), .result(alu_result));

    // beq/bne test zero from sub, the rest bit 0 of slt/sltu, funct3[0] inverts
    assign taken = (ir[14] ? alu_result[0] : (alu_result == 64'd0)) ^ ir[12];

    always_comb begin
        unique case (cu_next_pc)
            NPC_JAL:    npc = pc + imm_j;
            NPC_JALR:   npc = (rs1_data + imm_i) & ~64'd1;
            NPC_BRANCH: npc = taken ? pc + imm_b : pc + 64'd4;
            default:    npc = pc + 64'd4;
        endcase
    end

    assign stop       = cu_illegal | cu_halt;
    assign mem_access = cu_mem_read | cu_mem_write;
    assign fetching   = (state == ST_FETCH);
    assign lsu_req    = (fetching && !wb_cyc) || (state == ST_EXEC && mem_access);
    assign rf_we      = (state == ST_EXEC && cu_rf_we && !cu_mem_read)
                      || (state == ST_MEM && lsu_done && cu_mem_read);

    reg_file u_reg_file (
        .clk(clk), .arst_n(arst_n),
        .rs1_addr(ir[19:15]), .rs2_addr(ir[24:20]), .rd_addr(ir[11:7]),
        .rd_data((cu_rf_src == RF_LOAD) ? lsu_read_data : alu_result),
        .we(rf_we), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    load_store_unit #(.ADDR_W(ADDR_W)) u_load_store_unit (
        .clk(clk), .arst_n(arst_n), .req(lsu_req),
        .addr(fetching ? pc[ADDR_W-1:0] : alu_result[ADDR_W-1:0]),
        .write(!fetching && cu_mem_write),
        .size(fetching ? SIZE_W : cu_mem_size),
        .load_unsigned(fetching || cu_load_unsigned),
        .store_data(rs2_data), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .done(lsu_done), .read_data(lsu_read_data),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
        .wb_we(wb_we), .wb_cyc(wb_cyc), .wb_stb(wb_stb)
    );

    always_ff @(posedge clk) begin
        if (fetching && lsu_done) ir <= lsu_read_data[31:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_FETCH;
            pc      <= RESET_PC;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            unique case (state)
                ST_FETCH: if (lsu_done) state <= ST_EXEC;
                ST_EXEC: begin
                    if (stop) begin
                        state   <= ST_STOP;
                        halted  <= 1'b1;
                        illegal <= cu_illegal;
                    end else if (mem_access) begin
                        state <= ST_MEM;
                    end else begin
                        pc    <= npc;
                        state <= ST_FETCH;
                    end
                end
                ST_MEM: begin
                    if (lsu_done) begin // load or store retires here
                        pc    <= npc;
                        state <= ST_FETCH;
                    end
                end
                default: state <= ST_STOP; // held until reset
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // rv64i major opcodes
    typedef enum logic [6:0] {
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_OP_32     = 7'b0111011,
        OPC_SYSTEM    = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B    // lui
    } alu_op_e;

    typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

    typedef enum logic [2:0] {
        SRC2_RS2,
        SRC2_IMM_I,
        SRC2_IMM_S,
        SRC2_IMM_U,
        SRC2_FOUR     // link value pc + 4
    } src2_sel_e;

    typedef enum logic [1:0] {NPC_SEQ, NPC_JAL, NPC_JALR, NPC_BRANCH} next_pc_e;

    typedef enum logic {RF_ALU, RF_LOAD} rf_src_e;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W, SIZE_D} mem_size_e;

    typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_MEM, ST_STOP} seq_state_e;

endpackage

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    input  logic rst_req,
    output logic clk,
    output logic arst_n
);

    logic clk_q = 1'b0;
    logic rst_q = 1'b0;
    int   hold  = 5;

    always #50 clk_q = ~clk_q; // 100 ns period

    // reset held low for 5 rising edges, again on each request
    always @(posedge clk_q) begin
        if (rst_req) begin
            rst_q <= 1'b0;
            hold  <= 5;
        end else if (hold > 0) begin
            hold  <= hold - 1;
            rst_q <= (hold == 1);
        end
    end

    assign clk    = clk_q;
    assign arst_n = rst_q;

endmodule

`default_nettype wire

//--- testbench/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core;

    localparam logic [63:0] START = 64'h100;

    logic        clk;
    logic        arst_n;
    logic        rst_req  = 1'b0;
    logic [63:0] wb_dat_r = 64'd0;
    logic        wb_ack   = 1'b0;
    logic [15:0] wb_adr;
    logic [63:0] wb_dat_w;
    logic [7:0]  wb_sel;
    logic        wb_we, wb_cyc, wb_stb, halted, illegal;

    logic [63:0] mem [1024];
    logic [63:0] image [1024];   // program image copied into mem on reset request
    logic [63:0] ref_mem [1024];
    logic [63:0] exp_adr [$];
    logic [63:0] exp_sel [$];
    logic [63:0] exp_dat [$];
    logic        exp_illegal;
    logic [31:0] lfsr      = 32'd93465;
    logic        busy      = 1'b0;
    logic [1:0]  wait_left = 2'd0;
    logic [63:0] pa;
    int          so;
    int          errors = 0;

    tb_clock u_clock (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

    riscv_core #(.RESET_PC(START), .ADDR_W(16)) dut (
        .clk(clk), .arst_n(arst_n), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_we(wb_we),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .halted(halted), .illegal(illegal)
    );

    function automatic logic next_rand_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) lfsr = lfsr ^ 32'h80200003; // galois taps 32 22 2 1
        return out;
    endfunction

    // wishbone slave with 0 to 3 wait states
    always @(posedge clk) begin
        if (rst_req) begin
            mem = image;
            busy = 1'b0;
            wb_ack <= 1'b0;
        end else if (wb_ack) begin
            if (wb_we) begin
                for (int k = 0; k < 8; k++) begin
                    if (wb_sel[k]) mem[wb_adr[12:3]][8*k +: 8] = wb_dat_w[8*k +: 8];
                end
            end
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left[1] = next_rand_bit();
                wait_left[0] = next_rand_bit();
            end
            if (wait_left == 2'd0) begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[wb_adr[12:3]];
                busy = 1'b0;
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd,
                                          logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(int imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic void emit(logic [31:0] w);
        if (pa[2]) image[pa[12:3]][63:32] = w;
        else image[pa[12:3]][31:0] = w;
        pa = pa + 64'd4;
    endfunction

    function automatic void store_reg(int r);
        emit(enc_s(so, r, 11, 3)); // sd r, so(x11)
        so = so + 8;
    endfunction

    function automatic void fill_image();
        for (int i = 0; i < 1024; i++) begin
            image[i] = {32'(i) * 32'h9e3779b9, ~(32'(i) ^ 32'h5a5a5a5a)};
        end
        pa = START;
        so = 0;
    endfunction

    function automatic void build_prog_a();
        int br_f3 [6];
        int n;
        int id;
        br_f3 = '{0, 1, 4, 5, 6, 7};
        n = 0;
        id = 1;
        emit(enc_u(1, 10, 7'h37));               // x10 data base
        emit(enc_i(1024, 10, 0, 11, 7'h13));     // x11 result area
        emit(enc_i(-5, 0, 0, 1, 7'h13));
        emit(enc_i(7, 1, 3, 2, 7'h13));
        emit(enc_i(60, 1, 7, 3, 7'h13));
        emit(enc_i(2047, 1, 0, 4, 7'h1b));
        emit(enc_u('h87654, 5, 7'h37));
        emit(enc_i('h321, 5, 0, 5, 7'h13));
        emit(enc_i(32, 0, 0, 7, 7'h13));
        emit(enc_r(0, 7, 5, 1, 8, 7'h33));
        emit(enc_r(0, 8, 5, 4, 5, 7'h33));       // x5 full 64-bit pattern
        emit(enc_i(13, 0, 0, 9, 7'h13));
        emit(enc_r(0, 1, 5, 0, 12, 7'h33));
        emit(enc_r(32, 5, 1, 0, 13, 7'h33));
        emit(enc_r(0, 1, 5, 7, 14, 7'h33));
        emit(enc_r(0, 1, 5, 6, 15, 7'h33));
        emit(enc_r(0, 1, 5, 2, 16, 7'h33));
        emit(enc_r(0, 1, 5, 3, 17, 7'h33));
        emit(enc_r(0, 9, 5, 1, 19, 7'h33));
        emit(enc_r(0, 9, 5, 5, 20, 7'h33));
        emit(enc_r(32, 9, 5, 5, 21, 7'h33));
        emit(enc_r(0, 5, 5, 0, 22, 7'h3b));
        emit(enc_i(2047, 5, 0, 23, 7'h1b));
        emit(enc_u(3, 24, 7'h17));
        emit(enc_u('hfffff, 25, 7'h37));
        for (int r = 1; r <= 25; r++) store_reg(r);
        // every size at every aligned lane with signed and unsigned reloads
        for (int sz = 0; sz < 4; sz++) begin
            for (int off = 0; off < 8; off += (1 << sz)) begin
                emit(enc_s(sz * 8 + off, (n % 2 == 1) ? 1 : 5, 10, sz));
                emit(enc_i(sz * 8 + off, 10, sz, 6, 7'h03));
                store_reg(6);
                if (sz < 3) begin
                    emit(enc_i(sz * 8 + off, 10, sz + 4, 6, 7'h03));
                    store_reg(6);
                end
                n++;
            end
        end
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                emit(enc_i(id, 0, 0, 26, 7'h13));
                emit(enc_b(8, (p == 0) ? 2 : 1, (p == 1) ? 2 : 1, br_f3[f]));
                emit(enc_i(id + 100, 0, 0, 26, 7'h13)); // skipped when taken
                store_reg(26);
                id++;
            end
        end
        emit(enc_j(8, 27));
        emit(enc_i(77, 0, 0, 26, 7'h13));
        store_reg(27);
        store_reg(26);
        emit(enc_u(0, 28, 7'h17));
        emit(enc_i(13, 28, 0, 29, 7'h67));       // odd target with bit 0 dropped
        emit(enc_i(55, 0, 0, 26, 7'h13));
        store_reg(29);
        store_reg(26);
        emit(enc_i(3, 0, 0, 30, 7'h13));
        emit(enc_i(-1, 30, 0, 30, 7'h13));
        store_reg(30);
        emit(enc_b(-8, 0, 30, 1));               // backward bne
        emit(32'h00100073);                      // ebreak
    endfunction

    function automatic void build_prog_b();
        emit(enc_u(1, 10, 7'h37));
        emit(enc_i(9, 0, 0, 1, 7'h13));
        emit(enc_s(0, 1, 10, 3));
        emit(32'h00000000);                      // undefined encoding
        emit(32'h00100073);
    endfunction

    // instruction set interpreter over ref_mem
    function automatic void run_reference();
        logic [63:0] x [32];
        logic [63:0] pc, npc, a, b, r, ea, v, sel;
        logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;
        logic [31:0] in;
        logic [2:0]  f3;
        logic        wr, stop, taken;
        exp_adr.delete();
        exp_sel.delete();
        exp_dat.delete();
        exp_illegal = 1'b0;
        for (int i = 0; i < 32; i++) x[i] = 64'd0;
        pc = START;
        stop = 1'b0;
        for (int n = 0; n < 5000 && !stop; n++) begin
            v = ref_mem[pc[12:3]];
            in = pc[2] ? v[63:32] : v[31:0];
            f3 = in[14:12];
            a = x[in[19:15]];
            b = x[in[24:20]];
            imm_i = {{52{in[31]}}, in[31:20]};
            imm_s = {{52{in[31]}}, in[31:25], in[11:7]};
            imm_b = {{52{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
            imm_u = {{32{in[31]}}, in[31:12], 12'h000};
            imm_j = {{44{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
            npc = pc + 64'd4;
            r = 64'd0;
            wr = 1'b1;
            taken = 1'b0;
            case (in[6:0])
                7'h13: begin
                    case (f3)
                        3'd0: r = a + imm_i;
                        3'd3: r = {63'd0, a < imm_i};
                        3'd7: r = a & imm_i;
                        default: exp_illegal = 1'b1;
                    endcase
                end
                7'h1b: begin
                    r = a + imm_i;
                    r = {{32{r[31]}}, r[31:0]};
                    if (f3 != 3'd0) exp_illegal = 1'b1;
                end
                7'h37: r = imm_u;
                7'h17: r = pc + imm_u;
                7'h6f: begin
                    r = pc + 64'd4;
                    npc = pc + imm_j;
                end
                7'h67: begin
                    r = pc + 64'd4;
                    npc = (a + imm_i) & ~64'd1;
                    if (f3 != 3'd0) exp_illegal = 1'b1;
                end
                7'h33: begin
                    case ({in[31:25], f3})
                        10'h000: r = a + b;
                        10'h100: r = a - b;
                        10'h001: r = a << b[5:0];
                        10'h002: r = {63'd0, $signed(a) < $signed(b)};
                        10'h003: r = {63'd0, a < b};
                        10'h004: r = a ^ b;
                        10'h005: r = a >> b[5:0];
                        10'h105: r = $signed(a) >>> b[5:0];
                        10'h006: r = a | b;
                        10'h007: r = a & b;
                        default: exp_illegal = 1'b1;
                    endcase
                end
                7'h3b: begin
                    r = a + b;
                    r = {{32{r[31]}}, r[31:0]};
                    if ({in[31:25], f3} != 10'h000) exp_illegal = 1'b1;
                end
                7'h63: begin
                    wr = 1'b0;
                    case (f3)
                        3'd0: taken = (a == b);
                        3'd1: taken = (a != b);
                        3'd4: taken = ($signed(a) < $signed(b));
                        3'd5: taken = ($signed(a) >= $signed(b));
                        3'd6: taken = (a < b);
                        3'd7: taken = (a >= b);
                        default: exp_illegal = 1'b1;
                    endcase
                    if (taken) npc = pc + imm_b;
                end
                7'h03: begin
                    ea = a + imm_i;
                    v = ref_mem[ea[12:3]] >> {ea[2:0], 3'b000};
                    case (f3)
                        3'd0: r = {{56{v[7]}}, v[7:0]};
                        3'd1: r = {{48{v[15]}}, v[15:0]};
                        3'd2: r = {{32{v[31]}}, v[31:0]};
                        3'd3: r = v;
                        3'd4: r = {56'd0, v[7:0]};
                        3'd5: r = {48'd0, v[15:0]};
                        3'd6: r = {32'd0, v[31:0]};
                        default: exp_illegal = 1'b1;
                    endcase
                end
                7'h23: begin
                    wr = 1'b0;
                    ea = a + imm_s;
                    sel = ((64'd1 << (64'd1 << f3[1:0])) - 64'd1) << ea[2:0];
                    v = b << {ea[2:0], 3'b000};
                    if (f3[2]) begin
                        exp_illegal = 1'b1;
                    end else begin
                        exp_adr.push_back({48'd0, ea[15:3], 3'b000});
                        exp_sel.push_back({56'd0, sel[7:0]});
                        exp_dat.push_back(v);
                        for (int k = 0; k < 8; k++) begin
                            if (sel[k]) ref_mem[ea[12:3]][8*k +: 8] = v[8*k +: 8];
                        end
                    end
                end
                7'h73: begin
                    wr = 1'b0;
                    stop = 1'b1;
                    if (in != 32'h00100073) exp_illegal = 1'b1;
                end
                default: exp_illegal = 1'b1;
            endcase
            if (exp_illegal) stop = 1'b1;
            if (!stop) begin
                if (wr && in[11:7] != 5'd0) x[in[11:7]] = r;
                pc = npc;
            end
        end
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic request_reset();
        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
    endtask

    task automatic check_startup();
        int t;
        t = 0;
        while (arst_n && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (arst_n) begin
            errors++;
            $display("timeout: reset was never asserted");
        end
        @(negedge clk);
        check("wb_cyc", 64'(wb_cyc), 64'd0);
        check("wb_stb", 64'(wb_stb), 64'd0);
        check("halted", 64'(halted), 64'd0);
        check("illegal", 64'(illegal), 64'd0);
        t = 0;
        while (!arst_n && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (!arst_n) begin
            errors++;
            $display("timeout: reset was never released");
        end
        t = 0;
        while (!wb_cyc && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (!wb_cyc) begin
            errors++;
            $display("timeout: no fetch started after reset");
        end else begin
            check("wb_adr", 64'(wb_adr), START);
            check("wb_we", 64'(wb_we), 64'd0);
        end
    endtask

    task automatic run_to_halt();
        int t;
        t = 0;
        while (!halted && t < 20000) begin
            @(negedge clk);
            t++;
            if (wb_cyc && wb_ack && wb_we) begin
                if (exp_adr.size() == 0) begin
                    errors++;
                    $display("store at %0t when no store was expected", $time);
                end else begin
                    check("wb_adr", 64'(wb_adr), exp_adr.pop_front());
                    check("wb_sel", 64'(wb_sel), exp_sel.pop_front());
                    check("wb_dat_w", wb_dat_w, exp_dat.pop_front());
                end
            end
        end
        if (!halted) begin
            errors++;
            $display("timeout: core never halted");
        end else begin
            check("illegal", 64'(illegal), 64'(exp_illegal));
            check("stores left", 64'(exp_adr.size()), 64'd0);
            for (int i = 0; i < 20; i++) begin
                @(negedge clk);
                check("wb_cyc", 64'(wb_cyc), 64'd0); // no bus after stop
            end
        end
    endtask

    initial begin
        fill_image();
        build_prog_a();
        ref_mem = image;
        run_reference();
        request_reset();
        check_startup();
        run_to_halt();
        fill_image();
        build_prog_b();
        ref_mem = image;
        run_reference();
        request_reset();
        check_startup();
        run_to_halt();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
